// ==== Makefile ====
# Verilator build and run of the u1e core testbench

VERILATOR ?= verilator
TOP       ?= tb_u1e_core
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(shell grep -v '^+' $(FILELIST))

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "Verification failed" $(LOG) || ! grep -q "Verification passed" $(LOG); then \
		echo "Simulation did not pass, see $(LOG)"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== sim/tb_u1e_core.sv ====
// Testbench for u1e_core with host bus tasks, xorshift stimulus, stream model, checks and timeout
`timescale 1ns/1ps

module tb_u1e_core;

   localparam int N_CHAN     = 2;
   localparam int FIFO_DEPTH = 4;
   localparam int CHAN_W     = $clog2(N_CHAN);
   localparam int N_SAMPLES  = 40;
   localparam int ACK_LIMIT  = 8;
   localparam logic [31:0] SEED = 32'd20113;

   // Cycle budget of each test
   localparam int LEN_DEFAULTS = 16 + 60;
   localparam int LEN_REGS     = 16 + 4 * 12;
   localparam int LEN_STREAM   = 20 + N_SAMPLES * 21 * 2;  // Slowest rate on both channels
   localparam int LEN_STOP     = 20 + 30 + 50;
   localparam int LEN_OVERRUN  = 80;
   localparam int RUN_LIMIT    =
      (LEN_DEFAULTS + LEN_REGS + LEN_STREAM + LEN_STOP + LEN_OVERRUN) * 3 / 2;

   localparam logic [10:0] RB_BASE  = 11'h380;  // Region 7
   localparam logic [10:0] SET_BASE = 11'h400;  // Bit 10 set

   logic              wb_clk;
   logic              wb_rst;
   logic [10:0]       wb_adr_i;
   logic [15:0]       wb_dat_i;
   logic              wb_we_i;
   logic              wb_cyc_i;
   logic              wb_stb_i;
   logic [15:0]       wb_dat_o;
   logic              wb_ack_o;
   logic [2:0]        cgen_st_i;
   logic              cgen_sync_b_o;
   logic              cgen_ref_sel_o;
   logic [11:0]       rx_i_i;
   logic [11:0]       rx_q_i;
   logic [31:0]       rx_data_o;
   logic [CHAN_W-1:0] rx_chan_o;
   logic              rx_src_rdy_o;
   logic              rx_dst_rdy_i;

   logic [11:0] adc_cnt;
   logic        dst_random;
   logic        dst_level;
   logic [31:0] rng;
   int          n_checks;
   int          n_errors;
   int          cycle_cnt;
   int          decim_m [N_CHAN];
   logic [31:0] got_q [N_CHAN][$];  // Received words per channel

   u1e_core #(.N_CHAN(N_CHAN), .FIFO_DEPTH(FIFO_DEPTH)) u_u1e_core (
      .wb_clk(wb_clk), .wb_rst(wb_rst),
      .wb_adr_i(wb_adr_i), .wb_dat_i(wb_dat_i), .wb_we_i(wb_we_i),
      .wb_cyc_i(wb_cyc_i), .wb_stb_i(wb_stb_i),
      .wb_dat_o(wb_dat_o), .wb_ack_o(wb_ack_o),
      .cgen_st_i(cgen_st_i), .cgen_sync_b_o(cgen_sync_b_o), .cgen_ref_sel_o(cgen_ref_sel_o),
      .rx_i_i(rx_i_i), .rx_q_i(rx_q_i),
      .rx_data_o(rx_data_o), .rx_chan_o(rx_chan_o),
      .rx_src_rdy_o(rx_src_rdy_o), .rx_dst_rdy_i(rx_dst_rdy_i)
   );

   initial
   begin
      wb_clk = 1'b0;
      forever #4 wb_clk = ~wb_clk;
   end

   // ADC pattern where I counts up and Q is its inverse
   initial
   begin
      adc_cnt = '0;
      forever
      begin
         @(posedge wb_clk);
         #1;
         adc_cnt = adc_cnt + 12'd1;
      end
   end

   assign rx_i_i = adc_cnt;
   assign rx_q_i = ~adc_cnt;

   function automatic logic [31:0] xorshift32(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   // Sink ready is random or held at a level
   initial
   begin : dst_driver
      logic [31:0] s;
      s = SEED ^ 32'h9E3779B9;
      rx_dst_rdy_i = 1'b0;
      forever
      begin
         @(posedge wb_clk);
         #1;
         if (dst_random)
         begin
            s = xorshift32(s);
            rx_dst_rdy_i = (s[1:0] != 2'b00);  // High three times in four
         end
         else
            rx_dst_rdy_i = dst_level;
      end
   end

   initial
   begin
      cycle_cnt = 0;
      while (cycle_cnt < RUN_LIMIT)
      begin
         @(posedge wb_clk);
         cycle_cnt++;
      end
      $display("Timeout, the run did not end within %0d cycles", RUN_LIMIT);
      $display("Verification failed");
      $finish;
   end

   //////////////////////////////
   // Check and bus helpers
   task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
      n_checks++;
      assert (got == exp)
      else
      begin
         $display("Fail %s: got %h, expected %h", name, got, exp);
         n_errors++;
      end
   endtask

   task automatic check_true(input logic cond, input string what);
      n_checks++;
      assert (cond)
      else
      begin
         $display("Error: %s", what);
         n_errors++;
      end
   endtask

   task automatic idle(input int n);
      repeat (n)
      begin
         @(posedge wb_clk);
         #1;
      end
   endtask

   task automatic apply_reset();
      wb_rst = 1'b1;
      idle(16);
      wb_rst = 1'b0;
      idle(1);
   endtask

   task automatic bus_access(input logic [10:0] adr, input logic [15:0] dat, input logic we,
                             output logic [15:0] rdata);
      int waits;
      waits    = 0;
      wb_adr_i = adr;
      wb_dat_i = dat;
      wb_we_i  = we;
      wb_cyc_i = 1'b1;
      wb_stb_i = 1'b1;
      @(negedge wb_clk);
      while (!wb_ack_o && waits < ACK_LIMIT)
      begin
         @(negedge wb_clk);
         waits++;
      end
      check_true(wb_ack_o, $sformatf("no acknowledge from the host bus at address %h", adr));
      rdata = wb_dat_o;
      @(posedge wb_clk);
      #1;
      wb_cyc_i = 1'b0;
      wb_stb_i = 1'b0;
      wb_we_i  = 1'b0;
   endtask

   task automatic bus_write(input logic [10:0] adr, input logic [15:0] dat);
      logic [15:0] unused;
      bus_access(adr, dat, 1'b1, unused);
   endtask

   task automatic bus_read(input logic [10:0] adr, output logic [15:0] dat);
      bus_access(adr, 16'd0, 1'b0, dat);
   endtask

   task automatic read_word(input int word, output logic [31:0] val);
      logic [15:0] lo;
      logic [15:0] hi;
      bus_read(RB_BASE | 11'(word * 4), lo);
      bus_read(RB_BASE | 11'(word * 4 + 2), hi);
      val = {hi, lo};
   endtask

   // Low half goes before the high half
   task automatic set_write(input int addr, input logic [31:0] val);
      logic [10:0] base;
      base = SET_BASE | 11'(addr * 4);
      bus_write(base, val[15:0]);
      bus_write(base | 11'd2, val[31:16]);
      idle(2);  // Wait for the strobe and the channel update
   endtask

   function automatic int ctrl_addr(input int chan);
      return u1e_pkg::SR_RX_DSP0 + chan * u1e_pkg::SR_CHAN_STRIDE;
   endfunction

   function automatic logic [31:0] ctrl_word(input logic run, input int decim);
      return {run, 23'd0, 8'(decim)};
   endfunction

   function automatic logic channels_short(input int need);
      for (int k = 0; k < N_CHAN; k++)
         if (got_q[k].size() < need)
            return 1'b1;
      return 1'b0;
   endfunction

   function automatic int total_words();
      int sum;
      sum = 0;
      for (int k = 0; k < N_CHAN; k++)
         sum += got_q[k].size();
      return sum;
   endfunction

   task automatic report_test(input int num, input string name, input int err_mark);
      if (n_errors == err_mark)
         $display("Test %0d %s: ok", num, name);
      else
         $display("Test %0d %s: %0d errors", num, name, n_errors - err_mark);
   endtask

   //////////////////////////////
   // Stream model
   // A word moves when src_rdy and dst_rdy are both high
   always @(negedge wb_clk)
   begin : stream_model
      logic [31:0] prev;
      logic [11:0] step;
      logic [11:0] q_exp;
      int          ch;
      if (!wb_rst && rx_src_rdy_o && rx_dst_rdy_i)
      begin
         ch = int'(rx_chan_o);
         q_exp = ~rx_data_o[31:20];
         check_eq("rx_data_o Q", 32'(rx_data_o[15:4]), 32'(q_exp));
         check_eq("rx_data_o pad", 32'({rx_data_o[19:16], rx_data_o[3:0]}), 32'd0);
         // A word on the wrong channel breaks that channel's step
         if (got_q[ch].size() > 0)
         begin
            prev = got_q[ch][$];
            step = rx_data_o[31:20] - prev[31:20];
            check_eq("rx_data_o I step", 32'(step), 32'(12'(decim_m[ch] + 1)));
         end
         got_q[ch].push_back(rx_data_o);
      end
   end

   initial
   begin : main
      logic [15:0] rd;
      logic [31:0] rd32;
      logic [31:0] last32;
      int          err_mark;
      int          total;
      int          waits;
      logic        stayed_low;

      wb_rst     = 1'b1;
      wb_adr_i   = '0;
      wb_dat_i   = '0;
      wb_we_i    = 1'b0;
      wb_cyc_i   = 1'b0;
      wb_stb_i   = 1'b0;
      cgen_st_i  = '0;
      dst_random = 1'b0;
      dst_level  = 1'b0;
      rng        = SEED;
      n_checks   = 0;
      n_errors   = 0;
      for (int k = 0; k < N_CHAN; k++)
         decim_m[k] = 0;

      // Test 1 checks the reset defaults
      err_mark = n_errors;
      apply_reset();
      bus_read(11'(u1e_pkg::REG_CGEN_CTRL), rd);
      check_eq("wb_dat_o cgen_ctrl", 32'(rd), 32'h3);
      check_eq("cgen_sync_b_o", 32'(cgen_sync_b_o), 32'h1);
      check_eq("cgen_ref_sel_o", 32'(cgen_ref_sel_o), 32'h1);
      bus_read(11'(u1e_pkg::REG_TEST), rd);
      check_eq("wb_dat_o reg_test", 32'(rd), 32'h0);
      for (int v = 0; v < 8; v++)
      begin
         cgen_st_i = 3'(v);
         bus_read(11'(u1e_pkg::REG_CGEN_ST), rd);
         check_eq("wb_dat_o cgen_st", 32'(rd), 32'(v));
      end
      bus_read(11'd0, rd);
      check_eq("wb_dat_o unused 0", 32'(rd), 32'hBEEF);
      bus_read(11'd2, rd);
      check_eq("wb_dat_o unused 2", 32'(rd), 32'hBEEF);
      bus_read(11'd10, rd);
      check_eq("wb_dat_o unused 10", 32'(rd), 32'hBEEF);
      read_word(2, rd32);
      check_eq("readback compat", rd32, {16'd9, 16'd4});
      read_word(3, rd32);
      check_eq("readback n_chan", rd32, 32'(N_CHAN));
      read_word(1, rd32);
      check_eq("readback overrun", rd32, 32'h0);
      stayed_low = 1'b1;
      repeat (20)
      begin
         idle(1);
         if (rx_src_rdy_o)
            stayed_low = 1'b0;
      end
      check_true(stayed_low, "rx_src_rdy_o rose with no channel running");
      report_test(1, "reset defaults", err_mark);

      // Test 2 writes the registers and reads them back
      err_mark = n_errors;
      last32   = '0;
      repeat (4)
      begin
         rng = xorshift32(rng);
         bus_write(11'(u1e_pkg::REG_TEST), rng[15:0]);
         bus_read(11'(u1e_pkg::REG_TEST), rd);
         check_eq("wb_dat_o reg_test", 32'(rd), 32'(rng[15:0]));
         rng    = xorshift32(rng);
         last32 = rng;
         set_write(u1e_pkg::SR_REG_TEST32, last32);
         read_word(0, rd32);
         check_eq("reg_test32", rd32, last32);
      end
      apply_reset();
      read_word(0, rd32);
      check_eq("reg_test32 after reset", rd32, last32);
      report_test(2, "register readback", err_mark);

      // Test 3 streams both channels
      err_mark = n_errors;
      for (int k = 0; k < N_CHAN; k++)
      begin
         rng = xorshift32(rng);
         decim_m[k] = 7 + int'(rng % 14);
         // Distinct rates so that a mislabelled word breaks its queue's step
         while (k > 0 && decim_m[k] == decim_m[k - 1])
         begin
            rng = xorshift32(rng);
            decim_m[k] = 7 + int'(rng % 14);
         end
      end
      dst_random = 1'b1;
      for (int k = 0; k < N_CHAN; k++)
         set_write(ctrl_addr(k), ctrl_word(1'b1, decim_m[k]));
      waits = 0;
      while (channels_short(N_SAMPLES) && waits < LEN_STREAM)
      begin
         idle(1);
         waits++;
      end
      check_true(!channels_short(N_SAMPLES),
                 $sformatf("stream stalled before each channel gave %0d samples", N_SAMPLES));
      read_word(1, rd32);
      check_eq("readback overrun", rd32, 32'h0);
      report_test(3, "streaming", err_mark);

      // Test 4 stops the channels and drains the stream
      err_mark = n_errors;
      for (int k = 0; k < N_CHAN; k++)
         set_write(ctrl_addr(k), ctrl_word(1'b0, decim_m[k]));
      dst_random = 1'b0;
      dst_level  = 1'b1;
      idle(30);
      total      = total_words();
      stayed_low = 1'b1;
      repeat (50)
      begin
         idle(1);
         if (rx_src_rdy_o)
            stayed_low = 1'b0;
      end
      check_true(stayed_low, "rx_src_rdy_o high after both channels stopped and drained");
      check_eq("stream word count", 32'(total_words()), 32'(total));
      report_test(4, "stop", err_mark);

      // Test 5 forces an overrun with the sink blocked
      err_mark  = n_errors;
      dst_level = 1'b0;
      idle(2);
      for (int k = 0; k < N_CHAN; k++)
         got_q[k].delete();  // Dropped samples break the sequence
      decim_m[0] = 0;
      set_write(ctrl_addr(0), ctrl_word(1'b1, 0));
      idle(FIFO_DEPTH + 4);
      read_word(1, rd32);
      check_eq("readback overrun", rd32, 32'h1);
      check_true(rx_src_rdy_o, "rx_src_rdy_o low while a blocked word waits");
      set_write(ctrl_addr(0), ctrl_word(1'b0, 0));
      set_write(u1e_pkg::SR_CLEAR_FIFO, 32'd0);
      waits = 0;
      while (rx_src_rdy_o && waits < 8)
      begin
         idle(1);
         waits++;
      end
      check_true(!rx_src_rdy_o, "rx_src_rdy_o still high after the FIFO clear");
      set_write(ctrl_addr(0) + 1, 32'd0);
      read_word(1, rd32);
      check_eq("readback overrun after clear", rd32, 32'h0);
      report_test(5, "overrun", err_mark);

      $display("Checks run: %0d, errors: %0d", n_checks, n_errors);
      if (n_errors == 0)
         $display("Verification passed");
      else
         $display("Verification failed");
      $finish;
   end

endmodule

// ==== src.f ====
src/u1e_pkg.sv
src/wb_regs_decode.sv
src/settings_bus_16le.sv
src/rx_dsp_chan.sv
src/rx_stream_mux.sv
src/u1e_core.sv
sim/tb_u1e_core.sv

// ==== src/rx_dsp_chan.sv ====
// Receive channel with control setting, decimator, sample FIFO and sticky overrun flag
`timescale 1ns/1ps

module rx_dsp_chan #(
   parameter int CHAN_BASE  = 0,
   parameter int FIFO_DEPTH = 4
) (
   input  logic                         wb_clk,
   input  logic                         wb_rst,
   input  logic                         set_stb_i,
   input  logic [u1e_pkg::SET_AW-1:0]   set_addr_i,
   input  logic [u1e_pkg::SET_DW-1:0]   set_data_i,
   input  logic                         clear_fifo_i,
   input  logic [u1e_pkg::ADC_W-1:0]    rx_i_i,
   input  logic [u1e_pkg::ADC_W-1:0]    rx_q_i,
   output logic [u1e_pkg::SAMPLE_W-1:0] chan_data_o,
   output logic                         chan_valid_o,
   input  logic                         chan_pop_i,
   output logic                         overrun_o
);

   localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
   localparam int CNT_W = $clog2(FIFO_DEPTH + 1);
   localparam int PAD_W = u1e_pkg::SAMPLE_W / 2 - u1e_pkg::ADC_W;
   localparam logic [u1e_pkg::SET_AW-1:0] CTRL_ADDR    = u1e_pkg::SET_AW'(CHAN_BASE);
   localparam logic [u1e_pkg::SET_AW-1:0] OVR_CLR_ADDR = u1e_pkg::SET_AW'(CHAN_BASE + 1);

   u1e_pkg::rx_ctrl_u            ctrl;
   logic                         ctrl_wr;
   logic                         ovr_clr;
   logic [7:0]                   decim_cnt;
   logic                         capture;
   logic                         full;
   logic                         push;
   logic [u1e_pkg::SAMPLE_W-1:0] sample;
   logic [u1e_pkg::SAMPLE_W-1:0] mem [FIFO_DEPTH];
   logic [PTR_W-1:0]             wr_ptr;
   logic [PTR_W-1:0]             rd_ptr;
   logic [CNT_W-1:0]             count;

   function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
      return (p == PTR_W'(FIFO_DEPTH - 1)) ? '0 : p + 1'b1;
   endfunction

   assign ctrl_wr = set_stb_i && (set_addr_i == CTRL_ADDR);
   assign ovr_clr = set_stb_i && (set_addr_i == OVR_CLR_ADDR);

   //////////////////////////////
   // Control word and decimator
   always_ff @(posedge wb_clk)
   begin
      if (wb_rst)
      begin
         ctrl.raw  <= '0;
         decim_cnt <= '0;
      end
      else if (ctrl_wr)
      begin
         ctrl.raw  <= set_data_i;
         decim_cnt <= '0;  // Restart on every write
      end
      else if (ctrl.f.run)
         decim_cnt <= (decim_cnt == 8'd0) ? ctrl.f.decim : decim_cnt - 8'd1;
   end

   assign capture = ctrl.f.run & (decim_cnt == 8'd0);
   assign sample  = {rx_i_i, {PAD_W{1'b0}}, rx_q_i, {PAD_W{1'b0}}};

   //////////////////////////////
   // Sample FIFO
   assign full = (count == CNT_W'(FIFO_DEPTH));
   assign push = capture & ~full;

   always_ff @(posedge wb_clk)
   begin
      if (push)
         mem[wr_ptr] <= sample;
   end

   always_ff @(posedge wb_clk)
   begin
      if (wb_rst | clear_fifo_i)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end
      else
      begin
         if (push)
            wr_ptr <= ptr_inc(wr_ptr);
         if (chan_pop_i)
            rd_ptr <= ptr_inc(rd_ptr);
         count <= count + CNT_W'(push) - CNT_W'(chan_pop_i);
      end
   end

   assign chan_data_o  = mem[rd_ptr];
   assign chan_valid_o = (count != '0);

   // Sticky until the host clears it
   always_ff @(posedge wb_clk)
   begin
      if (wb_rst)
         overrun_o <= 1'b0;
      else if (capture & full)
         overrun_o <= 1'b1;
      else if (ovr_clr)
         overrun_o <= 1'b0;
   end

endmodule

// ==== src/rx_stream_mux.sv ====
// Round-robin merge of channel FIFOs into one src_rdy/dst_rdy output stream
`timescale 1ns/1ps

module rx_stream_mux #(
   parameter  int N_CHAN = 2,
   localparam int CHAN_W = (N_CHAN > 1) ? $clog2(N_CHAN) : 1
) (
   input  logic                                     wb_clk,
   input  logic                                     wb_rst,
   input  logic                                     clear_fifo_i,
   input  logic [N_CHAN-1:0][u1e_pkg::SAMPLE_W-1:0] chan_data_i,
   input  logic [N_CHAN-1:0]                        chan_valid_i,
   output logic [N_CHAN-1:0]                        chan_pop_o,
   output logic [u1e_pkg::SAMPLE_W-1:0]             rx_data_o,
   output logic [CHAN_W-1:0]                        rx_chan_o,
   output logic                                     rx_src_rdy_o,
   input  logic                                     rx_dst_rdy_i
);

   logic [CHAN_W-1:0] last;
   logic [CHAN_W-1:0] grant;
   logic              grant_vld;
   logic              take;

   // Search starts one past the last channel served
   always_comb
   begin
      int idx;
      grant_vld = 1'b0;
      grant     = last;
      for (int k = 1; k <= N_CHAN; k++)
      begin
         idx = (int'(last) + k) % N_CHAN;
         if (!grant_vld && chan_valid_i[idx])
         begin
            grant_vld = 1'b1;
            grant     = CHAN_W'(idx);
         end
      end
   end

   // Load when the output is empty or leaving this cycle
   assign take = grant_vld & (~rx_src_rdy_o | rx_dst_rdy_i) & ~clear_fifo_i;

   always_comb
   begin
      chan_pop_o = '0;
      if (take)
         chan_pop_o[grant] = 1'b1;
   end

   always_ff @(posedge wb_clk)
   begin
      if (wb_rst)
      begin
         rx_src_rdy_o <= 1'b0;
         last         <= CHAN_W'(N_CHAN - 1);  // Channel 0 goes first
      end
      else if (clear_fifo_i)
         rx_src_rdy_o <= 1'b0;
      else if (take)
      begin
         rx_src_rdy_o <= 1'b1;
         last         <= grant;
      end
      else if (rx_dst_rdy_i)
         rx_src_rdy_o <= 1'b0;
   end

   always_ff @(posedge wb_clk)
   begin
      if (take)
      begin
         rx_data_o <= chan_data_i[grant];
         rx_chan_o <= grant;
      end
   end

endmodule

// ==== src/settings_bus_16le.sv ====
// Settings bus assembly from 16-bit halves, persistent test register and FIFO clear pulse
`timescale 1ns/1ps

module settings_bus_16le (
   input  logic                        wb_clk,
   input  logic                        wb_rst,
   input  logic                        set_wr_i,
   input  logic [u1e_pkg::HOST_AW-1:0] wb_adr_i,
   input  logic [u1e_pkg::HOST_DW-1:0] wb_dat_i,
   output logic                        set_stb_o,
   output logic [u1e_pkg::SET_AW-1:0]  set_addr_o,
   output logic [u1e_pkg::SET_DW-1:0]  set_data_o,
   output logic [u1e_pkg::SET_DW-1:0]  reg_test32_o,
   output logic                        clear_fifo_o
);

   logic [u1e_pkg::HOST_DW-1:0] low_half;
   u1e_pkg::rx_ctrl_u           set_word;
   logic                        hi_wr;

   assign hi_wr = set_wr_i & wb_adr_i[1];

   // Low half waits here until the high half arrives
   always_ff @(posedge wb_clk)
   begin
      if (set_wr_i & ~wb_adr_i[1])
         low_half <= wb_dat_i;
      if (hi_wr)
      begin
         set_addr_o   <= wb_adr_i[u1e_pkg::SET_AW+1:2];
         set_word.raw <= {wb_dat_i, low_half};
      end
   end

   always_ff @(posedge wb_clk)
   begin
      if (wb_rst)
         set_stb_o <= 1'b0;
      else
         set_stb_o <= hi_wr;  // One cycle pulse
   end

   assign set_data_o = set_word.raw;

   //////////////////////////////
   // Test register, survives reset so the host can tell a reload
   always_ff @(posedge wb_clk)
   begin
      if (set_stb_o && set_addr_o == u1e_pkg::SET_AW'(u1e_pkg::SR_REG_TEST32))
         reg_test32_o <= set_data_o;
   end

   always_ff @(posedge wb_clk)
   begin
      if (wb_rst)
         clear_fifo_o <= 1'b0;
      else
         clear_fifo_o <= set_stb_o &&
                         (set_addr_o == u1e_pkg::SET_AW'(u1e_pkg::SR_CLEAR_FIFO));
   end

endmodule

// ==== src/u1e_core.sv ====
// Top level with host decode, settings bus, receive channel loop and stream mux
`timescale 1ns/1ps

module u1e_core #(
   parameter  int N_CHAN     = 2,
   parameter  int FIFO_DEPTH = 4,
   localparam int CHAN_W     = (N_CHAN > 1) ? $clog2(N_CHAN) : 1
) (
   input  logic                         wb_clk,
   input  logic                         wb_rst,
   input  logic [u1e_pkg::HOST_AW-1:0]  wb_adr_i,
   input  logic [u1e_pkg::HOST_DW-1:0]  wb_dat_i,
   input  logic                         wb_we_i,
   input  logic                         wb_cyc_i,
   input  logic                         wb_stb_i,
   output logic [u1e_pkg::HOST_DW-1:0]  wb_dat_o,
   output logic                         wb_ack_o,
   input  logic [2:0]                   cgen_st_i,
   output logic                         cgen_sync_b_o,
   output logic                         cgen_ref_sel_o,
   input  logic [u1e_pkg::ADC_W-1:0]    rx_i_i,
   input  logic [u1e_pkg::ADC_W-1:0]    rx_q_i,
   output logic [u1e_pkg::SAMPLE_W-1:0] rx_data_o,
   output logic [CHAN_W-1:0]            rx_chan_o,
   output logic                         rx_src_rdy_o,
   input  logic                         rx_dst_rdy_i
);

   logic                                     set_wr;
   logic                                     set_stb;
   logic [u1e_pkg::SET_AW-1:0]               set_addr;
   logic [u1e_pkg::SET_DW-1:0]               set_data;
   logic [u1e_pkg::SET_DW-1:0]               reg_test32;
   logic                                     clear_fifo;
   logic [N_CHAN-1:0]                        overrun;
   logic [N_CHAN-1:0][u1e_pkg::SAMPLE_W-1:0] chan_data;
   logic [N_CHAN-1:0]                        chan_valid;
   logic [N_CHAN-1:0]                        chan_pop;

   //////////////////////////////
   // Host side
   wb_regs_decode #(.N_CHAN(N_CHAN)) u_wb_regs_decode (
      .wb_clk(wb_clk), .wb_rst(wb_rst),
      .wb_adr_i(wb_adr_i), .wb_dat_i(wb_dat_i), .wb_we_i(wb_we_i),
      .wb_cyc_i(wb_cyc_i), .wb_stb_i(wb_stb_i),
      .wb_dat_o(wb_dat_o), .wb_ack_o(wb_ack_o), .set_wr_o(set_wr),
      .reg_test32_i(reg_test32), .overrun_i(overrun), .cgen_st_i(cgen_st_i),
      .cgen_sync_b_o(cgen_sync_b_o), .cgen_ref_sel_o(cgen_ref_sel_o)
   );

   settings_bus_16le u_settings_bus_16le (
      .wb_clk(wb_clk), .wb_rst(wb_rst), .set_wr_i(set_wr),
      .wb_adr_i(wb_adr_i), .wb_dat_i(wb_dat_i),
      .set_stb_o(set_stb), .set_addr_o(set_addr), .set_data_o(set_data),
      .reg_test32_o(reg_test32), .clear_fifo_o(clear_fifo)
   );

   //////////////////////////////
   // Receive channels
   for (genvar g = 0; g < N_CHAN; g++)
   begin : g_chan
      rx_dsp_chan #(
         .CHAN_BASE(u1e_pkg::SR_RX_DSP0 + g * u1e_pkg::SR_CHAN_STRIDE),
         .FIFO_DEPTH(FIFO_DEPTH)
      ) u_rx_dsp_chan (
         .wb_clk(wb_clk), .wb_rst(wb_rst),
         .set_stb_i(set_stb), .set_addr_i(set_addr), .set_data_i(set_data),
         .clear_fifo_i(clear_fifo), .rx_i_i(rx_i_i), .rx_q_i(rx_q_i),
         .chan_data_o(chan_data[g]), .chan_valid_o(chan_valid[g]),
         .chan_pop_i(chan_pop[g]), .overrun_o(overrun[g])
      );
   end

   rx_stream_mux #(.N_CHAN(N_CHAN)) u_rx_stream_mux (
      .wb_clk(wb_clk), .wb_rst(wb_rst), .clear_fifo_i(clear_fifo),
      .chan_data_i(chan_data), .chan_valid_i(chan_valid), .chan_pop_o(chan_pop),
      .rx_data_o(rx_data_o), .rx_chan_o(rx_chan_o),
      .rx_src_rdy_o(rx_src_rdy_o), .rx_dst_rdy_i(rx_dst_rdy_i)
   );

endmodule

// ==== src/u1e_pkg.sv ====
// Bus widths, settings address map, misc offsets, compat number and channel control word
package u1e_pkg;

   //////////////////////////////
   // Bus and sample widths
   localparam int HOST_DW  = 16;  // Host data
   localparam int HOST_AW  = 11;  // Host byte address
   localparam int SET_AW   = 8;
   localparam int SET_DW   = 32;
   localparam int ADC_W    = 12;
   localparam int SAMPLE_W = 32;  // I in upper half, Q in lower half

   //////////////////////////////
   // Settings address map
   localparam int SR_RX_DSP0     = 0;
   localparam int SR_CHAN_STRIDE = 2;   // +0 control, +1 overrun clear
   localparam int SR_REG_TEST32  = 60;
   localparam int SR_CLEAR_FIFO  = 61;

   //////////////////////////////
   // Host regions from address bits 10 to 7
   localparam logic [3:0] SLAVE_MISC     = 4'h0;
   localparam logic [3:0] SLAVE_READBACK = 4'h7;
   localparam logic [3:0] SLAVE_SETTINGS = 4'h8;  // Any code with the top bit set

   // Misc register byte offsets
   localparam logic [6:0] REG_CGEN_CTRL = 7'd4;  // out
   localparam logic [6:0] REG_CGEN_ST   = 7'd6;  // in
   localparam logic [6:0] REG_TEST      = 7'd8;  // out

   localparam logic [HOST_DW-1:0] MISC_DEFAULT = 16'hBEEF;

   // Bump when the register map changes
   localparam logic [SET_DW-1:0] COMPAT_NUM = {16'd9, 16'd4};  // major, minor

   // Channel control word, written raw and decoded by field
   typedef union packed {
      logic [SET_DW-1:0] raw;
      struct packed {
         logic        run;
         logic [22:0] rsvd;
         logic [7:0]  decim;  // Keep one sample in decim+1
      } f;
   } rx_ctrl_u;

endpackage

// ==== src/wb_regs_decode.sv ====
// Host region decode, misc registers, 32-bit readback mux and read data steering
`timescale 1ns/1ps

module wb_regs_decode #(
   parameter int N_CHAN = 2
) (
   input  logic                        wb_clk,
   input  logic                        wb_rst,
   input  logic [u1e_pkg::HOST_AW-1:0] wb_adr_i,
   input  logic [u1e_pkg::HOST_DW-1:0] wb_dat_i,
   input  logic                        wb_we_i,
   input  logic                        wb_cyc_i,
   input  logic                        wb_stb_i,
   output logic [u1e_pkg::HOST_DW-1:0] wb_dat_o,
   output logic                        wb_ack_o,
   output logic                        set_wr_o,
   input  logic [u1e_pkg::SET_DW-1:0]  reg_test32_i,
   input  logic [N_CHAN-1:0]           overrun_i,
   input  logic [2:0]                  cgen_st_i,
   output logic                        cgen_sync_b_o,
   output logic                        cgen_ref_sel_o
);

   logic [3:0]                  region;
   logic                        hit;
   logic                        is_misc;
   logic                        is_rb;
   logic                        is_set;
   logic [6:0]                  misc_off;
   logic [3:0]                  rb_word;
   logic [u1e_pkg::HOST_DW-1:0] misc_data;
   logic [u1e_pkg::SET_DW-1:0]  rb_data;
   logic [u1e_pkg::HOST_DW-1:0] reg_cgen_ctrl;
   logic [u1e_pkg::HOST_DW-1:0] reg_test;

   assign region   = wb_adr_i[u1e_pkg::HOST_AW-1 -: 4];
   assign misc_off = wb_adr_i[6:0];
   assign rb_word  = wb_adr_i[5:2];
   assign hit      = wb_cyc_i & wb_stb_i;

   assign is_misc = (region == u1e_pkg::SLAVE_MISC);
   assign is_rb   = (region == u1e_pkg::SLAVE_READBACK);
   assign is_set  = |(region & u1e_pkg::SLAVE_SETTINGS);

   assign wb_ack_o = hit;  // Every slave answers at once
   assign set_wr_o = hit & wb_we_i & is_set;

   //////////////////////////////
   // Misc registers
   always_ff @(posedge wb_clk)
   begin
      if (wb_rst)
      begin
         reg_cgen_ctrl <= 16'd3;  // Sync released, ref select high
         reg_test      <= '0;
      end
      else if (hit & wb_we_i & is_misc)
      begin
         case (misc_off)
            u1e_pkg::REG_CGEN_CTRL : reg_cgen_ctrl <= wb_dat_i;
            u1e_pkg::REG_TEST      : reg_test      <= wb_dat_i;
            default                : ;
         endcase
      end
   end

   assign cgen_sync_b_o  = reg_cgen_ctrl[1];
   assign cgen_ref_sel_o = reg_cgen_ctrl[0];

   always_comb
   begin
      case (misc_off)
         u1e_pkg::REG_CGEN_CTRL : misc_data = reg_cgen_ctrl;
         u1e_pkg::REG_CGEN_ST   : misc_data = {13'd0, cgen_st_i};
         u1e_pkg::REG_TEST      : misc_data = reg_test;
         default                : misc_data = u1e_pkg::MISC_DEFAULT;
      endcase
   end

   //////////////////////////////
   // Readback mux
   always_comb
   begin
      case (rb_word)
         4'd0    : rb_data = reg_test32_i;
         4'd1    : rb_data = u1e_pkg::SET_DW'(overrun_i);  // Bit k is channel k
         4'd2    : rb_data = u1e_pkg::COMPAT_NUM;
         4'd3    : rb_data = u1e_pkg::SET_DW'(N_CHAN);
         default : rb_data = '0;
      endcase
   end

   // Read data steering, address bit 1 picks the high half
   always_comb
   begin
      if (is_misc)
         wb_dat_o = misc_data;
      else if (is_rb)
         wb_dat_o = wb_adr_i[1] ? rb_data[31:16] : rb_data[15:0];
      else
         wb_dat_o = '0;
   end

endmodule
